// ==== design/cpuPkg.sv ====
package cpuPkg;

    // decoded class of an instruction word.
    typedef enum logic [3:0] {
        ADD_R,
        SUB_R,
        AND_R,
        OR_R,
        SLT_R,
        BREAK_R,
        ADDI_I,
        ORI_I,
        LUI_I,
        INT_I,
        UNKNOWN
    } opcodes;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK
    } states;

    // trap cause handed from the exception logic to the controller.
    typedef enum logic [1:0] {
        NO_OP,
        BREAK_EXC,
        SYS_EXC,
        UNK_EXC
    } controlBus;

    // field positions inside the 32 bit word.
    parameter int OP_FIELD_HI    = 31;
    parameter int OP_FIELD_LO    = 26;
    parameter int RS_FIELD_LO    = 21;
    parameter int RT_FIELD_LO    = 16;
    parameter int RD_FIELD_LO    = 11;
    parameter int FUNCT_FIELD_HI = 5;
    parameter int FUNCT_FIELD_LO = 0;
    parameter int IMM_FIELD_HI   = 15;
    parameter int IMM_FIELD_LO   = 0;

    // r-type function codes used with opcode 0.
    parameter logic [5:0] OP_RTYPE    = 6'h00;
    parameter logic [5:0] FUNCT_ADD   = 6'h20;
    parameter logic [5:0] FUNCT_SUB   = 6'h22;
    parameter logic [5:0] FUNCT_AND   = 6'h24;
    parameter logic [5:0] FUNCT_OR    = 6'h25;
    parameter logic [5:0] FUNCT_SLT   = 6'h2A;
    parameter logic [5:0] FUNCT_BREAK = 6'h0D;

    parameter logic [5:0] OP_ADDI = 6'h08;
    parameter logic [5:0] OP_ORI  = 6'h0D;
    parameter logic [5:0] OP_LUI  = 6'h0F;
    parameter logic [5:0] OP_INT  = 6'h3F;

    typedef struct packed {
        opcodes      op;
        logic [4:0]  rsIdx;
        logic [4:0]  rtIdx;
        logic [4:0]  rdIdx;
        logic [15:0] imm;
    } decodedInstr;

    typedef struct packed {
        logic take;
        logic executeNow;
        logic writeNow;
        logic trapNow;
    } stageStrobes;

    typedef struct packed {
        logic        valid;
        logic [4:0]  regIdx;
        logic [31:0] data;
    } writeReport;

    typedef struct packed {
        logic      valid;
        controlBus cause;
    } trapReport;

endpackage

// ==== design/instructionDecoder.sv ====
`timescale 1ns/10ps

module instructionDecoder #(
    parameter int REG_COUNT = 8
) (
    input  logic [31:0]         instructionWord,
    output cpuPkg::decodedInstr decoded
);

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [5:0]     opField;
    logic [5:0]     functField;
    cpuPkg::opcodes opClass;

    assign opField    = instructionWord[cpuPkg::OP_FIELD_HI:cpuPkg::OP_FIELD_LO];
    assign functField = instructionWord[cpuPkg::FUNCT_FIELD_HI:cpuPkg::FUNCT_FIELD_LO];

    // register indices keep only the bits the register file can address.
    assign decoded.rsIdx = 5'(instructionWord[cpuPkg::RS_FIELD_LO +: IDX_W]);
    assign decoded.rtIdx = 5'(instructionWord[cpuPkg::RT_FIELD_LO +: IDX_W]);
    assign decoded.rdIdx = 5'(instructionWord[cpuPkg::RD_FIELD_LO +: IDX_W]);
    assign decoded.imm   = instructionWord[cpuPkg::IMM_FIELD_HI:cpuPkg::IMM_FIELD_LO];
    assign decoded.op    = opClass;

    always_comb begin
        opClass = cpuPkg::UNKNOWN;

        case (opField)
            cpuPkg::OP_RTYPE: begin
                case (functField)
                    cpuPkg::FUNCT_ADD:   opClass = cpuPkg::ADD_R;
                    cpuPkg::FUNCT_SUB:   opClass = cpuPkg::SUB_R;
                    cpuPkg::FUNCT_AND:   opClass = cpuPkg::AND_R;
                    cpuPkg::FUNCT_OR:    opClass = cpuPkg::OR_R;
                    cpuPkg::FUNCT_SLT:   opClass = cpuPkg::SLT_R;
                    cpuPkg::FUNCT_BREAK: opClass = cpuPkg::BREAK_R;
                    default:             opClass = cpuPkg::UNKNOWN;
                endcase
            end

            cpuPkg::OP_ADDI: opClass = cpuPkg::ADDI_I;
            cpuPkg::OP_ORI:  opClass = cpuPkg::ORI_I;
            cpuPkg::OP_LUI:  opClass = cpuPkg::LUI_I;
            cpuPkg::OP_INT:  opClass = cpuPkg::INT_I;

            // all remaining encodings fall into one class.
            default: opClass = cpuPkg::UNKNOWN;
        endcase
    end

endmodule

// ==== design/sequenceController.sv ====
`timescale 1ns/10ps

module sequenceController (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              instrValid,
    input  logic [31:0]       instrWord,
    input  cpuPkg::controlBus exceptionTriggerControl,
    output cpuPkg::states     state,
    output logic [31:0]       instructionWord,
    output cpuPkg::stageStrobes strobes
);

    cpuPkg::states stateNext;
    logic          trapPending;

    assign trapPending = (exceptionTriggerControl != cpuPkg::NO_OP);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= cpuPkg::FETCH;
        else if (enable)
            state <= stateNext;
    end

    // instruction register.
    always_ff @(posedge clk) begin
        if (strobes.take)
            instructionWord <= instrWord;
    end

    always_comb begin
        stateNext = state;

        case (state)
            cpuPkg::FETCH:     if (instrValid) stateNext = cpuPkg::DECODE;
            cpuPkg::DECODE:    stateNext = cpuPkg::EXECUTE;
            cpuPkg::EXECUTE:   stateNext = trapPending ? cpuPkg::FETCH : cpuPkg::WRITEBACK;
            cpuPkg::WRITEBACK: stateNext = cpuPkg::FETCH;
            default:           stateNext = cpuPkg::FETCH;
        endcase
    end

    // strobes fire only in cycles that actually advance.
    always_comb begin
        strobes = '0;

        if (enable) begin
            case (state)
                cpuPkg::FETCH:     strobes.take = instrValid;
                cpuPkg::EXECUTE: begin
                    strobes.executeNow = !trapPending;
                    strobes.trapNow    = trapPending;
                end
                cpuPkg::WRITEBACK: strobes.writeNow = 1'b1;
                default:           strobes = '0;
            endcase
        end
    end

    strobesOneHot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(strobes)
    );

endmodule

// ==== design/exceptionTriggerOutputLogic.sv ====
`timescale 1ns/10ps

module exceptionTriggerOutputLogic (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  cpuPkg::opcodes    instruction,
    input  cpuPkg::states     state,
    output cpuPkg::controlBus exceptionTriggerControl
);

    cpuPkg::controlBus exceptionTriggerControlNext;

    // held while stalled.
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            exceptionTriggerControl <= cpuPkg::NO_OP;
        else if (enable)
            exceptionTriggerControl <= exceptionTriggerControlNext;
    end

    always_comb begin
        exceptionTriggerControlNext = cpuPkg::NO_OP;

        case (state)
            cpuPkg::DECODE: begin
                case (instruction)
                    cpuPkg::BREAK_R: exceptionTriggerControlNext = cpuPkg::BREAK_EXC;
                    cpuPkg::INT_I:   exceptionTriggerControlNext = cpuPkg::SYS_EXC;
                    cpuPkg::UNKNOWN: exceptionTriggerControlNext = cpuPkg::UNK_EXC;
                    default:         exceptionTriggerControlNext = cpuPkg::NO_OP;
                endcase
            end

            default: exceptionTriggerControlNext = cpuPkg::NO_OP;
        endcase
    end

    // the cause lives exactly as long as the EXECUTE state that consumes it.
    causeOnlyInExecute: assert property (
        @(posedge clk) disable iff (reset)
        (exceptionTriggerControl != cpuPkg::NO_OP) |-> (state == cpuPkg::EXECUTE)
    );

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit #(
    parameter int REG_COUNT = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  cpuPkg::decodedInstr decoded,
    input  cpuPkg::stageStrobes strobes,
    output logic [31:0]         aluResult,
    output logic [4:0]          destIdx
);

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [31:0] regFile [REG_COUNT];
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic [31:0] immSigned;
    logic [31:0] immZero;
    logic [31:0] aluNext;
    logic [4:0]  destNext;

    // register 0 always reads zero.
    assign rsValue = (decoded.rsIdx == '0) ? '0 : regFile[decoded.rsIdx[IDX_W-1:0]];
    assign rtValue = (decoded.rtIdx == '0) ? '0 : regFile[decoded.rtIdx[IDX_W-1:0]];

    assign immSigned = {{16{decoded.imm[15]}}, decoded.imm};
    assign immZero   = {16'h0000, decoded.imm};

    always_comb begin
        aluNext  = '0;
        destNext = decoded.rdIdx;

        case (decoded.op)
            cpuPkg::ADD_R: aluNext = rsValue + rtValue;
            cpuPkg::SUB_R: aluNext = rsValue - rtValue;
            cpuPkg::AND_R: aluNext = rsValue & rtValue;
            cpuPkg::OR_R:  aluNext = rsValue | rtValue;
            cpuPkg::SLT_R: aluNext = 32'($signed(rsValue) < $signed(rtValue));
            cpuPkg::ADDI_I: begin
                aluNext  = rsValue + immSigned;
                destNext = decoded.rtIdx;
            end
            cpuPkg::ORI_I: begin
                aluNext  = rsValue | immZero;
                destNext = decoded.rtIdx;
            end
            cpuPkg::LUI_I: begin
                aluNext  = {decoded.imm, 16'h0000};
                destNext = decoded.rtIdx;
            end
            default: begin
                aluNext  = '0;
                destNext = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluResult <= '0;
            destIdx   <= '0;
            for (int i = 0; i < REG_COUNT; i++)
                regFile[i] <= '0;
        end else if (enable) begin
            if (strobes.executeNow) begin
                aluResult <= aluNext;
                destIdx   <= destNext;
            end
            if (strobes.writeNow && destIdx != '0)
                regFile[destIdx[IDX_W-1:0]] <= aluResult;
        end
    end

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/10ps

module resultStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  cpuPkg::stageStrobes strobes,
    input  cpuPkg::controlBus   exceptionTriggerControl,
    input  logic [31:0]         aluResult,
    input  logic [4:0]          destIdx,
    output cpuPkg::writeReport  writeOut,
    output cpuPkg::trapReport   trapOut
);

    cpuPkg::writeReport writeReg;
    cpuPkg::trapReport  trapReg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            writeReg <= '0;
            trapReg  <= '0;
        end else if (enable) begin
            writeReg.valid <= strobes.writeNow;
            if (strobes.writeNow) begin
                writeReg.regIdx <= destIdx;
                writeReg.data   <= aluResult;
            end

            trapReg.valid <= strobes.trapNow;
            if (strobes.trapNow)
                trapReg.cause <= exceptionTriggerControl;
        end
    end

    // a report held across a stall shows up once enable returns.
    always_comb begin
        writeOut       = writeReg;
        writeOut.valid = writeReg.valid & enable;
        trapOut        = trapReg;
        trapOut.valid  = trapReg.valid & enable;
    end

    reportsExclusive: assert property (
        @(posedge clk) disable iff (reset) !(writeOut.valid && trapOut.valid)
    );

endmodule

// ==== design/miniCore.sv ====
`timescale 1ns/10ps

module miniCore #(
    parameter int REG_COUNT = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               instrValid,
    input  logic [31:0]        instrWord,
    output logic               instrTaken,
    output cpuPkg::writeReport writeOut,
    output cpuPkg::trapReport  trapOut
);

    cpuPkg::states       state;
    cpuPkg::stageStrobes strobes;
    cpuPkg::decodedInstr decoded;
    cpuPkg::controlBus   exceptionTriggerControl;
    logic [31:0]         instructionWord;
    logic [31:0]         aluResult;
    logic [4:0]          destIdx;

    assign instrTaken = strobes.take;

    sequenceController controller (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .instrValid              (instrValid),
        .instrWord               (instrWord),
        .exceptionTriggerControl (exceptionTriggerControl),
        .state                   (state),
        .instructionWord         (instructionWord),
        .strobes                 (strobes)
    );

    instructionDecoder #(.REG_COUNT(REG_COUNT)) decoder (
        .instructionWord (instructionWord),
        .decoded         (decoded)
    );

    exceptionTriggerOutputLogic exceptionLogic (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .instruction             (decoded.op),
        .state                   (state),
        .exceptionTriggerControl (exceptionTriggerControl)
    );

    executeUnit #(.REG_COUNT(REG_COUNT)) execute (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .decoded   (decoded),
        .strobes   (strobes),
        .aluResult (aluResult),
        .destIdx   (destIdx)
    );

    resultStage result (
        .clk                     (clk),
        .reset                   (reset),
        .enable                  (enable),
        .strobes                 (strobes),
        .exceptionTriggerControl (exceptionTriggerControl),
        .aluResult               (aluResult),
        .destIdx                 (destIdx),
        .writeOut                (writeOut),
        .trapOut                 (trapOut)
    );

endmodule

// ==== sim/miniCoreTb.sv ====
`timescale 1ns/10ps

module miniCoreTb;

    localparam int REG_COUNT      = 8;
    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 16 + 100;

    // one expected report per taken instruction in take order.
    typedef struct packed {
        logic        isTrap;
        logic        timed;
        logic [4:0]  regIdx;
        logic [31:0] data;
        logic [1:0]  cause;
        logic [31:0] seq;
        logic [31:0] takeCycle;
    } expectEntry;

    logic               clk = 1'b0;
    logic               reset;
    logic               enable;
    logic               instrValid;
    logic [31:0]        instrWord;
    logic               instrTaken;
    cpuPkg::writeReport writeOut;
    cpuPkg::trapReport  trapOut;

    logic [31:0] randState = 32'h7816;
    logic [31:0] modelRegs [REG_COUNT];
    expectEntry  expectQueue [$];
    logic [31:0] directedWords [$];
    int          cycleCount = 0;
    int          takenCount = 0;
    logic        timedPhase = 1'b0;

    miniCore #(.REG_COUNT(REG_COUNT)) UUT (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .instrTaken (instrTaken),
        .writeOut   (writeOut),
        .trapOut    (trapOut)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] nextRandom();
        randState = xorshift32(randState);
        return randState;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // 16 of 20 picks are legal kinds, then BREAK, INT and two unused-code picks.
    function automatic logic [31:0] randomInstruction();
        logic [31:0] pick;
        logic [31:0] f;
        logic [5:0]  code;
        logic [31:0] word;
        pick = nextRandom() % 32'd20;
        f    = nextRandom();
        code = 6'(nextRandom() >> 26);
        case (pick)
            32'd16: word = rType(6'h0D, f[4:0], f[9:5], f[14:10]);
            32'd17: word = iType(6'h3F, f[4:0], f[9:5], f[31:16]);
            32'd18: word = rType(code inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h2A, 6'h0D} ?
                                 6'h3E : code, f[4:0], f[9:5], f[14:10]);
            32'd19: word = iType(code inside {6'h00, 6'h08, 6'h0D, 6'h0F, 6'h3F} ?
                                 6'h01 : code, f[4:0], f[9:5], f[31:16]);
            default: begin
                case (pick % 32'd8)
                    32'd0: word = rType(6'h20, f[4:0], f[9:5], f[14:10]);
                    32'd1: word = rType(6'h22, f[4:0], f[9:5], f[14:10]);
                    32'd2: word = rType(6'h24, f[4:0], f[9:5], f[14:10]);
                    32'd3: word = rType(6'h25, f[4:0], f[9:5], f[14:10]);
                    32'd4: word = rType(6'h2A, f[4:0], f[9:5], f[14:10]);
                    32'd5: word = iType(6'h08, f[4:0], f[9:5], f[31:16]);
                    32'd6: word = iType(6'h0D, f[4:0], f[9:5], f[31:16]);
                    default: word = iType(6'h0F, f[4:0], f[9:5], f[31:16]);
                endcase
            end
        endcase
        return word;
    endfunction

    // reference model with indices taken from the low bits of each field.
    task automatic applyModel(input logic [31:0] word, output expectEntry e);
        int          rs;
        int          rt;
        int          dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        rs   = int'(word[25:21]) % REG_COUNT;
        rt   = int'(word[20:16]) % REG_COUNT;
        dest = int'(word[15:11]) % REG_COUNT;
        imm  = word[15:0];
        a    = modelRegs[rs];
        b    = modelRegs[rt];
        e    = '0;
        case (word[31:26])
            6'h00: begin
                case (word[5:0])
                    6'h20: e.data = a + b;
                    6'h22: e.data = a - b;
                    6'h24: e.data = a & b;
                    6'h25: e.data = a | b;
                    6'h2A: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h0D: e.cause = cpuPkg::BREAK_EXC;
                    default: e.cause = cpuPkg::UNK_EXC;
                endcase
            end
            6'h08: e.data = a + {{16{imm[15]}}, imm};
            6'h0D: e.data = a | {16'h0000, imm};
            6'h0F: e.data = {imm, 16'h0000};
            6'h3F: e.cause = cpuPkg::SYS_EXC;
            default: e.cause = cpuPkg::UNK_EXC;
        endcase
        if (word[31:26] != 6'h00)
            dest = rt;
        e.isTrap = (e.cause != 2'd0);
        e.regIdx = 5'(dest);
        // register 0 keeps reading zero.
        if (!e.isTrap && dest != 0)
            modelRegs[dest] = e.data;
    endtask

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", testName, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", testName);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkReport(input expectEntry e);
        string tag;
        tag = $sformatf("instr %0d", e.seq);
        compareValue({tag, " kind"}, 32'(e.isTrap), 32'(trapOut.valid));
        if (e.isTrap)
            compareValue({tag, " cause"}, 32'(e.cause), 32'(trapOut.cause));
        else begin
            compareValue({tag, " index"}, 32'(e.regIdx), 32'(writeOut.regIdx));
            compareValue({tag, " data"}, e.data, writeOut.data);
        end
        if (e.timed)
            compareValue({tag, " latency"}, e.isTrap ? 32'd3 : 32'd4,
                         32'(cycleCount) - e.takeCycle);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            abortRun("run timed out before all reports arrived");
    end

    // outputs are sampled mid cycle.
    always @(negedge clk) begin
        expectEntry e;
        if (!reset) begin
            if (!enable && (writeOut.valid || trapOut.valid))
                abortRun("a report valid was high while enable was low");
            else if (writeOut.valid || trapOut.valid) begin
                if (expectQueue.size() == 0)
                    abortRun("a report arrived with no instruction outstanding");
                else
                    checkReport(expectQueue.pop_front());
            end
            if (instrTaken) begin
                applyModel(instrWord, e);
                e.seq       = 32'(takenCount);
                e.takeCycle = 32'(cycleCount);
                e.timed     = timedPhase;
                expectQueue.push_back(e);
                takenCount  = takenCount + 1;
            end
        end
    end

    // the word is held until taken, then replaced or the bus goes idle.
    task automatic runInstructions(input logic directed, input int count);
        int startCount;
        int presented;
        startCount = takenCount;
        presented  = 0;
        timedPhase = directed;
        while (takenCount - startCount < count) begin
            @(posedge clk);
            #1;
            if (directed)
                enable = 1'b1;
            else
                enable = (nextRandom() % 32'd4 != 32'd0);
            if (presented == takenCount - startCount) begin
                if (presented < count && (directed || nextRandom() % 32'd5 != 32'd0)) begin
                    if (directed)
                        instrWord = directedWords[presented];
                    else
                        instrWord = randomInstruction();
                    instrValid = 1'b1;
                    presented  = presented + 1;
                end else begin
                    instrValid = 1'b0;
                    instrWord  = nextRandom();
                end
            end
        end
        enable = 1'b1;
        while (expectQueue.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    initial begin
        reset      = 1'b1;
        enable     = 1'b1;
        instrValid = 1'b0;
        instrWord  = 32'd0;
        for (int i = 0; i < REG_COUNT; i++)
            modelRegs[i] = 32'd0;
        // first reads of every register.
        for (int k = 0; k < REG_COUNT; k++)
            directedWords.push_back(rType(6'h25, 5'(k), 5'(k), 5'd0));
        directedWords.push_back(iType(6'h08, 5'd0, 5'd1, 16'h8001));
        directedWords.push_back(iType(6'h0D, 5'd0, 5'd2, 16'h8001));
        directedWords.push_back(iType(6'h0F, 5'd0, 5'd3, 16'h1234));
        directedWords.push_back(iType(6'h08, 5'd1, 5'd4, 16'h7FFF));
        directedWords.push_back(rType(6'h20, 5'd1, 5'd3, 5'd5));
        directedWords.push_back(rType(6'h22, 5'd2, 5'd3, 5'd6));
        directedWords.push_back(rType(6'h24, 5'd1, 5'd2, 5'd7));
        directedWords.push_back(rType(6'h25, 5'd2, 5'd3, 5'd5));
        directedWords.push_back(rType(6'h2A, 5'd1, 5'd2, 5'd6));
        directedWords.push_back(rType(6'h2A, 5'd2, 5'd1, 5'd7));
        // write aimed at register 0, then read it back.
        directedWords.push_back(iType(6'h08, 5'd3, 5'd0, 16'h0005));
        directedWords.push_back(rType(6'h20, 5'd0, 5'd0, 5'd1));
        directedWords.push_back(rType(6'h0D, 5'd1, 5'd2, 5'd3));
        directedWords.push_back(iType(6'h3F, 5'd1, 5'd2, 16'h0000));
        directedWords.push_back(iType(6'h01, 5'd1, 5'd2, 16'h0000));
        directedWords.push_back(rType(6'h21, 5'd1, 5'd2, 5'd3));
        directedWords.push_back(rType(6'h25, 5'd3, 5'd2, 5'd4));

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        compareValue("reset state", 32'd0,
                     32'({instrTaken, writeOut.valid, trapOut.valid}));

        runInstructions(1'b1, directedWords.size());
        runInstructions(1'b0, NUM_INSTR - directedWords.size());

        if (expectQueue.size() == 0 && takenCount == NUM_INSTR) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun("reports are missing or instructions were lost");
        end
    end

endmodule

// ==== verilog.f ====
design/cpuPkg.sv
design/instructionDecoder.sv
design/sequenceController.sv
design/exceptionTriggerOutputLogic.sv
design/executeUnit.sv
design/resultStage.sv
design/miniCore.sv
sim/miniCoreTb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary -j 0 --assert --timescale 1ns/10ps --top-module miniCoreTb \
    -f verilog.f -o miniCoreSim &&
    ./obj_dir/miniCoreSim > sim.log 2>&1 ||
    echo "build or simulation exited with an error"
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
